/* mesosync_pkg.sv */
`default_nettype none

package mesosync_pkg;

    // data word width, same on link and core sides
    localparam int WIDTH = 16;

    // input FIFO depth; the far side starts out with this many credits
    localparam int ELS = 8;

    // send credits held toward the link right after reset
    localparam int CREDIT_INITIAL = 8;

    // ceiling for every credit count in the design
    localparam int CREDIT_MAX = 8;

    // credits carried by one token pulse
    localparam int DECIMATION = 2;

    // derived widths
    localparam int PTR_W = $clog2(ELS);
    localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);

    // relay buffer occupancy
    typedef enum logic [1:0] {
        RELAY_EMPTY = 2'd0,
        RELAY_ONE   = 2'd1,
        RELAY_TWO   = 2'd2
    } relay_state_e;

endpackage

`default_nettype wire

/* mesosync_relay_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module mesosync_relay_fifo (
    input  wire                           clk_i,
    input  wire                           arst_n_i,
    // upstream side
    input  wire                           v_i,
    input  wire [mesosync_pkg::WIDTH-1:0] data_i,
    output logic                          ready_o,
    // downstream side
    output logic                          v_o,
    output logic [mesosync_pkg::WIDTH-1:0] data_o,
    input  wire                           ready_i
);

    import mesosync_pkg::*;

    relay_state_e state_r;
    relay_state_e state_nxt;

    // head word is what the consumer sees, skid word catches the overflow
    logic [WIDTH-1:0] head_r;
    logic [WIDTH-1:0] skid_r;

    logic enq;
    logic deq;

    assign enq = v_i & ready_o;
    assign deq = v_o & ready_i;
    assign data_o = head_r;

    // occupancy update
    always_comb begin
        state_nxt = state_r;
        case (state_r)
            RELAY_EMPTY: begin
                if (enq) state_nxt = RELAY_ONE;
            end
            RELAY_ONE: begin
                if (enq && !deq) state_nxt = RELAY_TWO;
                else if (!enq && deq) state_nxt = RELAY_EMPTY;
            end
            RELAY_TWO: begin
                // no enqueue possible here, ready_o is low
                if (deq) state_nxt = RELAY_ONE;
            end
            default: state_nxt = RELAY_EMPTY;
        endcase
    end

    // state plus registered handshake outputs
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_r <= RELAY_EMPTY;
            v_o     <= 1'b0;
            ready_o <= 1'b1;
        end else begin
            state_r <= state_nxt;
            v_o     <= (state_nxt != RELAY_EMPTY);
            // stays high with one entry held, so streaming has no bubble
            ready_o <= (state_nxt != RELAY_TWO);
        end
    end

    // payload path
    always_ff @(posedge clk_i) begin
        case (state_r)
            RELAY_EMPTY: begin
                if (enq) head_r <= data_i;
            end
            RELAY_ONE: begin
                // head leaving and a new word arriving, new word becomes head
                if (enq && deq) head_r <= data_i;
                else if (enq) skid_r <= data_i;
            end
            RELAY_TWO: begin
                if (deq) head_r <= skid_r;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* mesosync_credit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module mesosync_credit_fifo (
    input  wire                           clk_i,
    input  wire                           arst_n_i,
    // link side, valid only
    input  wire                           v_i,
    input  wire [mesosync_pkg::WIDTH-1:0] data_i,
    output logic                          credit_o,
    // consumer side, valid/yumi
    output logic                          v_o,
    output logic [mesosync_pkg::WIDTH-1:0] data_o,
    input  wire                           yumi_i
);

    import mesosync_pkg::*;

    // storage for the words the far side may have in flight
    logic [WIDTH-1:0] mem_r [ELS];

    // pointers carry one extra wrap bit to tell full from empty
    logic [PTR_W:0] wr_ptr_r;
    logic [PTR_W:0] rd_ptr_r;

    logic deq;

    // not empty while the pointers differ
    assign v_o = (wr_ptr_r != rd_ptr_r);
    assign data_o = mem_r[rd_ptr_r[PTR_W-1:0]];

    assign deq = yumi_i & v_o;

    // one freed slot per dequeue goes back as a credit, same cycle
    assign credit_o = deq;

    // write side
    // the far side only sends with credit, so no full check here
    always_ff @(posedge clk_i) begin
        if (v_i) begin
            mem_r[wr_ptr_r[PTR_W-1:0]] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_r <= '0;
        end else if (v_i) begin
            wr_ptr_r <= wr_ptr_r + 1'b1;
        end
    end

    // read side
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ptr_r <= '0;
        end else if (deq) begin
            rd_ptr_r <= rd_ptr_r + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* mesosync_credit_to_token.sv */
`timescale 1ns/1ps
`default_nettype none

module mesosync_credit_to_token (
    input  wire  clk_i,
    input  wire  arst_n_i,
    input  wire  credit_i,
    input  wire  line_ready_i,
    output logic token_o
);

    import mesosync_pkg::*;

    logic [CREDIT_W-1:0] pending_r;
    logic [CREDIT_W:0]   pending_sum;
    logic [CREDIT_W-1:0] pending_clamp;
    logic                fire;

    // count the incoming credit right away so the token follows one cycle later
    always_comb begin
        pending_sum = {1'b0, pending_r} + credit_i;
        if (pending_sum > CREDIT_MAX) pending_clamp = CREDIT_W'(CREDIT_MAX);
        else pending_clamp = pending_sum[CREDIT_W-1:0];
    end

    // a full batch is pending and the line can take a token
    assign fire = line_ready_i && (pending_clamp >= DECIMATION);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_r <= '0;
            token_o   <= 1'b0;
        end else begin
            token_o <= fire;
            // line not ready, credits just pile up
            if (fire) pending_r <= pending_clamp - CREDIT_W'(DECIMATION);
            else pending_r <= pending_clamp;
        end
    end

endmodule

`default_nettype wire

/* mesosync_credit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module mesosync_credit_counter (
    input  wire  clk_i,
    input  wire  arst_n_i,
    // valid/ready side, v_i already qualified by line_ready
    input  wire  v_i,
    output logic ready_o,
    // valid/credit side toward the link
    output logic v_o,
    input  wire  token_i
);

    import mesosync_pkg::*;

    logic [CREDIT_W-1:0] credit_r;
    logic [CREDIT_W:0]   credit_sum;
    logic [CREDIT_W-1:0] credit_nxt;
    logic                send;

    // any credit left means the far side has room
    assign ready_o = (credit_r != '0);

    // combinational pass from input valid to link valid
    assign send = v_i & ready_o;
    assign v_o = send;

    // send and token may land in the same cycle
    always_comb begin
        credit_sum = {1'b0, credit_r};
        if (token_i) begin
            credit_sum = credit_sum + (CREDIT_W + 1)'(DECIMATION);
        end
        if (send) begin
            credit_sum = credit_sum - 1'b1;
        end
        // saturate, a well behaved far side never hits this
        if (credit_sum > CREDIT_MAX) credit_nxt = CREDIT_W'(CREDIT_MAX);
        else credit_nxt = credit_sum[CREDIT_W-1:0];
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_r <= CREDIT_W'(CREDIT_INITIAL);
        end else begin
            credit_r <= credit_nxt;
        end
    end

endmodule

`default_nettype wire

/* mesosync_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mesosync_core (
    input  wire                            clk_i,
    input  wire                            arst_n_i,
    input  wire                            loopback_en_i,
    input  wire                            line_ready_i,
    // link input side
    input  wire [mesosync_pkg::WIDTH-1:0]  meso_data_i,
    input  wire                            meso_v_i,
    output logic                           meso_token_o,
    // link output side
    output logic                           meso_v_o,
    output logic [mesosync_pkg::WIDTH-1:0] meso_data_o,
    input  wire                            meso_token_i,
    // core input side
    input  wire [mesosync_pkg::WIDTH-1:0]  data_i,
    input  wire                            v_i,
    output logic                           ready_o,
    // core output side
    output logic                           v_o,
    output logic [mesosync_pkg::WIDTH-1:0] data_o,
    input  wire                            ready_i
);

    import mesosync_pkg::*;

    // input_relay output, heading for the link
    logic             in_relay_v;
    logic [WIDTH-1:0] in_relay_data;
    logic             in_relay_ready;

    // output_relay input, coming from the FIFO
    logic             out_relay_v;
    logic [WIDTH-1:0] out_relay_data;
    logic             out_relay_ready;

    // credit FIFO read side
    logic             fifo_v;
    logic [WIDTH-1:0] fifo_data;
    logic             fifo_yumi;
    logic             fifo_credit;

    // credit counter handshake
    logic             send_v;
    logic             cnt_ready;
    logic             send_ready;

    // relay on the long wire from the core
    mesosync_relay_fifo input_relay (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .v_i      (v_i),
        .data_i   (data_i),
        .ready_o  (ready_o),
        .v_o      (in_relay_v),
        .data_o   (in_relay_data),
        .ready_i  (in_relay_ready)
    );

    // relay on the long wire back to the core
    mesosync_relay_fifo output_relay (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .v_i      (out_relay_v),
        .data_i   (out_relay_data),
        .ready_o  (out_relay_ready),
        .v_o      (v_o),
        .data_o   (data_o),
        .ready_i  (ready_i)
    );

    // mode steering
    // loopback sends FIFO words back out, core paths sit idle
    assign send_v         = line_ready_i & (loopback_en_i ? fifo_v : in_relay_v);
    assign send_ready     = line_ready_i & cnt_ready;
    assign in_relay_ready = loopback_en_i ? 1'b0 : send_ready;
    assign meso_data_o    = loopback_en_i ? fifo_data : in_relay_data;
    assign out_relay_v    = loopback_en_i ? 1'b0 : fifo_v;
    assign out_relay_data = loopback_en_i ? '0 : fifo_data;

    // ready to yumi for the FIFO, consumer depends on the mode
    assign fifo_yumi = fifo_v & (loopback_en_i ? send_ready : out_relay_ready);

    mesosync_credit_fifo input_fifo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .v_i      (meso_v_i),
        .data_i   (meso_data_i),
        .credit_o (fifo_credit),
        .v_o      (fifo_v),
        .data_o   (fifo_data),
        .yumi_i   (fifo_yumi)
    );

    // freed FIFO slots go back to the far side in batches
    mesosync_credit_to_token token_gen (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .credit_i     (fifo_credit),
        .line_ready_i (line_ready_i),
        .token_o      (meso_token_o)
    );

    mesosync_credit_counter output_credit (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .v_i      (send_v),
        .ready_o  (cnt_ready),
        .v_o      (meso_v_o),
        .token_i  (meso_token_i)
    );

endmodule

`default_nettype wire

/* tb_mesosync_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mesosync_core;

    import mesosync_pkg::*;

    // words per phase
    localparam int N_CORE = 60;
    localparam int N_FAR = 60;
    localparam int N_LOOP = 20;
    localparam int N_LOOP_CORE = 4;
    localparam int TIMEOUT_CYCLES = (N_CORE + N_FAR + N_LOOP + N_LOOP_CORE) * 40 + 2000;

    logic clk_i, arst_n_i, loopback_en_i, line_ready_i;
    logic meso_v_i, meso_token_i, meso_token_o, meso_v_o;
    logic v_i, ready_o, v_o, ready_i;
    logic [WIDTH-1:0] meso_data_i, meso_data_o, data_i, data_o;

    integer seed = 12641;

    // expected words for the core to link, link to core and link to link paths
    logic [WIDTH-1:0] exp_link_q[$];
    logic [WIDTH-1:0] exp_core_q[$];
    logic [WIDTH-1:0] exp_loop_q[$];
    logic [WIDTH-1:0] exp_word;

    // written on the falling edge only
    logic core_acc = 1'b0;
    logic line_ready_d = 1'b1;
    int far_credit = ELS;
    int core_in_cnt = 0;
    int far_out_cnt = 0;
    int link_sent = 0;
    int loop_sent = 0;
    int loop_taken = 0;
    int delivered = 0;
    int tok_in = 0;
    int tok_out = 0;
    int rx_cnt = 0;
    int tok_due = 0;
    // written on the rising edge or by the main flow while the drivers idle
    int core_left = 0;
    int far_left = 0;
    int tok_sent = 0;
    int line_wait;
    int line_len;

    mesosync_core i_dut (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .loopback_en_i (loopback_en_i),
        .line_ready_i  (line_ready_i),
        .meso_data_i   (meso_data_i),
        .meso_v_i      (meso_v_i),
        .meso_token_o  (meso_token_o),
        .meso_v_o      (meso_v_o),
        .meso_data_o   (meso_data_o),
        .meso_token_i  (meso_token_i),
        .data_i        (data_i),
        .v_i           (v_i),
        .ready_o       (ready_o),
        .v_o           (v_o),
        .data_o        (data_o),
        .ready_i       (ready_i)
    );

    task automatic stop_run(input string why);
        $display("test failed");
        $display("%s", why);
        $fatal(1, "run stopped");
    endtask

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        stop_run($sformatf("Error: %s expected 0x%h, got 0x%h", name, exp, act));
    endtask

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        stop_run("timeout: traffic did not finish within the cycle limit");
    end

    // per cycle random draws happen only here so their order stays fixed
    always @(posedge clk_i) begin
        if (arst_n_i) begin
            // core side holds each word until it is taken
            if (!v_i || core_acc) begin
                if (core_left > 0 && ($random(seed) & 3) != 0) begin
                    v_i <= 1'b1;
                    data_i <= WIDTH'($random(seed));
                    core_left = core_left - 1;
                end else begin
                    v_i <= 1'b0;
                end
            end
            ready_i <= (($random(seed) & 3) != 0);
            // far side sends only with credit and while the line is up
            if (far_left > 0 && far_credit > 0 && line_ready_i && ($random(seed) & 1)) begin
                meso_v_i <= 1'b1;
                meso_data_i <= WIDTH'($random(seed));
                far_left = far_left - 1;
            end else begin
                meso_v_i <= 1'b0;
            end
            // token back to the DUT after a random delay
            if (tok_due > tok_sent && ($random(seed) & 1)) begin
                meso_token_i <= 1'b1;
                tok_sent = tok_sent + 1;
            end else begin
                meso_token_i <= 1'b0;
            end
        end
    end

    // monitors and scoreboards sample mid cycle
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            core_acc = v_i && ready_o;
            if (core_acc) begin
                exp_link_q.push_back(data_i);
                core_in_cnt++;
                if (loopback_en_i) loop_taken++;
            end
            if (meso_v_i) begin
                far_credit--;
                far_out_cnt++;
                if (loopback_en_i) exp_loop_q.push_back(meso_data_i);
                else exp_core_q.push_back(meso_data_i);
            end
            if (meso_token_o) begin
                far_credit += DECIMATION;
                tok_out++;
            end
            if (meso_v_o) begin
                link_sent++;
                // only tokens from earlier edges count toward the send credit
                assert (link_sent <= CREDIT_INITIAL + DECIMATION * tok_in)
                    else stop_run("meso_v_o fired with no send credit left");
                if (loopback_en_i) begin
                    assert (exp_loop_q.size() > 0) else stop_run("loopback word with none sent");
                    exp_word = exp_loop_q.pop_front();
                    loop_sent++;
                end else begin
                    assert (exp_link_q.size() > 0) else stop_run("link word with none accepted");
                    exp_word = exp_link_q.pop_front();
                end
                assert (meso_data_o == exp_word)
                    else value_error("meso_data_o", exp_word, meso_data_o);
                rx_cnt++;
                if (rx_cnt == DECIMATION) begin
                    rx_cnt = 0;
                    tok_due++;
                end
            end
            if (meso_token_i) tok_in++;
            if (v_o) begin
                assert (!loopback_en_i) else value_error("v_o", 0, v_o);
                if (ready_i) begin
                    assert (exp_core_q.size() > 0) else stop_run("core word with none sent");
                    exp_word = exp_core_q.pop_front();
                    assert (data_o == exp_word) else value_error("data_o", exp_word, data_o);
                    delivered++;
                end
            end
            // up to two dequeued words may still sit in output_relay
            assert (tok_out * DECIMATION <= delivered + loop_sent + 2)
                else value_error("meso_token_o count", (delivered + loop_sent + 2) / DECIMATION,
                                 tok_out);
            if (!line_ready_i) begin
                assert (!meso_v_o) else value_error("meso_v_o", 0, meso_v_o);
            end
            // token_o is registered, so it may trail the falling line by a cycle
            if (!line_ready_i && !line_ready_d) begin
                assert (!meso_token_o) else value_error("meso_token_o", 0, meso_token_o);
            end
            line_ready_d = line_ready_i;
        end
    end

    initial begin
        arst_n_i = 1'b0;
        loopback_en_i = 1'b0;
        line_ready_i = 1'b1;
        meso_data_i = '0;
        meso_v_i = 1'b0;
        meso_token_i = 1'b0;
        data_i = '0;
        v_i = 1'b0;
        ready_i = 1'b0;
        line_wait = 20 + ($random(seed) & 63);
        line_len = 8 + ($random(seed) & 31);
        repeat (8) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        assert (ready_o && !v_o && !meso_v_o && !meso_token_o)
            else stop_run("outputs not idle after reset");

        // normal mode runs both directions at once with one line drop in between
        core_left = N_CORE;
        far_left = N_FAR;
        repeat (line_wait) @(posedge clk_i);
        line_ready_i <= 1'b0;
        repeat (line_len) @(posedge clk_i);
        line_ready_i <= 1'b1;
        while (core_in_cnt < N_CORE || far_out_cnt < N_FAR ||
               exp_link_q.size() != 0 || exp_core_q.size() != 0) @(posedge clk_i);

        // in loopback the core words pile up in input_relay
        @(posedge clk_i);
        loopback_en_i <= 1'b1;
        @(negedge clk_i);
        core_left = N_LOOP_CORE;
        far_left = N_LOOP;
        while (far_out_cnt < N_FAR + N_LOOP || exp_loop_q.size() != 0) @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        assert (!ready_o) else value_error("ready_o", 0, ready_o);
        assert (loop_taken == 2) else value_error("words taken in loopback", 2, loop_taken);

        // back in normal mode the held core words drain to the link
        @(posedge clk_i);
        loopback_en_i <= 1'b0;
        while (core_in_cnt < N_CORE + N_LOOP_CORE || exp_link_q.size() != 0) @(posedge clk_i);
        repeat (10) @(posedge clk_i);
        assert (tok_out == (delivered + loop_sent) / DECIMATION)
            else value_error("meso_token_o count", (delivered + loop_sent) / DECIMATION, tok_out);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* mesosync_core.f */
mesosync_pkg.sv
mesosync_relay_fifo.sv
mesosync_credit_fifo.sv
mesosync_credit_to_token.sv
mesosync_credit_counter.sv
mesosync_core.sv
tb_mesosync_core.sv
